// File: verilog/core_pkg.sv
package core_pkg;

   // Datapath width, one bit handled per counting cycle
   localparam int XLEN = 32;

   // Bit counter covers XLEN cycles
   localparam int CNT_W = $clog2(XLEN);

   typedef logic [4:0] reg_addr_t;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_e;

endpackage

// File: verilog/isa_pkg.sv
package isa_pkg;

   // Major opcodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

   // funct3 codes shared by register and immediate arithmetic
   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;

   // funct7 codes for register form
   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_SUB  = 7'b0100000;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   // Same fetched word, viewed by format
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

endpackage

// File: verilog/exec_if.sv
`timescale 1ns/1ps

interface exec_if import core_pkg::*; ();

   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   reg_addr_t rd_addr;
   alu_op_e   alu_op;
   logic      use_imm;
   logic      rd_wen;
   // Immediate, one bit per execute cycle
   logic      imm_bit;

   modport decode (
      output rs1_addr, rs2_addr, rd_addr, alu_op, use_imm, rd_wen, imm_bit
   );

   modport seq (
      input rd_wen
   );

   modport alu (
      input alu_op, use_imm, imm_bit
   );

endinterface

// File: verilog/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch import core_pkg::*; #(
   parameter logic [XLEN-1:0] RESET_PC = '0
) (
   input  logic            i_clk,
   input  logic            i_rst_n,
   input  logic            i_ibus_ack,
   input  logic            i_next,
   output logic            o_ibus_cyc,
   output logic [XLEN-1:0] o_ibus_adr
);

   logic [XLEN-1:0] pc;
   logic            cyc;

   // Program counter, steps one word per retired instruction
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc <= RESET_PC;
      end else if (i_next) begin
         pc <= pc + XLEN'(4);
      end
   end

   // Bus request, raised again once the last bit has been written
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cyc <= 1'b1;
      end else if (i_next) begin
         cyc <= 1'b1;
      end else if (i_ibus_ack) begin
         cyc <= 1'b0;
      end
   end

   assign o_ibus_cyc = cyc;
   assign o_ibus_adr = pc;

endmodule

// File: verilog/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import core_pkg::*, isa_pkg::*; (
   input  logic        i_clk,
   input  logic        i_rst_n,
   input  logic        i_ibus_ack,
   input  logic [31:0] i_ibus_rdt,
   input  logic        i_cnt_en,
   exec_if.decode      o_op
);

   instr_u      word_in;
   instr_u      instr_q;
   logic [31:0] imm_q;
   alu_op_e     alu_op_d;
   logic        use_imm_d;
   logic        supported;

   function automatic logic f3_ok(input logic [2:0] f3);
      return (f3 == F3_ADD) || (f3 == F3_XOR) || (f3 == F3_OR) || (f3 == F3_AND);
   endfunction

   function automatic alu_op_e f3_to_op(input logic [2:0] f3);
      alu_op_e op;
      case (f3)
         F3_XOR:  op = ALU_XOR;
         F3_OR:   op = ALU_OR;
         F3_AND:  op = ALU_AND;
         default: op = ALU_ADD;
      endcase
      return op;
   endfunction

   assign word_in = i_ibus_rdt;

   // Cleared word has an unsupported opcode, so nothing writes before the first fetch
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         instr_q <= '0;
      end else if (i_ibus_ack) begin
         instr_q <= word_in;
      end
   end

   // Sign-extended I-immediate, shifted out lsb first
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         imm_q <= '0;
      end else if (i_ibus_ack) begin
         imm_q <= {{20{word_in.i.imm12[11]}}, word_in.i.imm12};
      end else if (i_cnt_en) begin
         imm_q <= {imm_q[31], imm_q[31:1]};
      end
   end

   always_comb begin
      alu_op_d  = ALU_ADD;
      use_imm_d = 1'b0;
      supported = 1'b0;
      case (instr_q.r.opcode)
         OPC_OP: begin
            if (instr_q.r.funct7 == F7_SUB && instr_q.r.funct3 == F3_ADD) begin
               alu_op_d  = ALU_SUB;
               supported = 1'b1;
            end else if (instr_q.r.funct7 == F7_BASE) begin
               alu_op_d  = f3_to_op(instr_q.r.funct3);
               supported = f3_ok(instr_q.r.funct3);
            end
         end
         OPC_OP_IMM: begin
            use_imm_d = 1'b1;
            alu_op_d  = f3_to_op(instr_q.i.funct3);
            supported = f3_ok(instr_q.i.funct3);
         end
         default: begin
            supported = 1'b0;
         end
      endcase
   end

   assign o_op.rs1_addr = instr_q.r.rs1;
   assign o_op.rs2_addr = instr_q.r.rs2;
   assign o_op.rd_addr  = instr_q.r.rd;
   assign o_op.alu_op   = alu_op_d;
   assign o_op.use_imm  = use_imm_d;
   // x0 is never written
   assign o_op.rd_wen   = supported && (instr_q.r.rd != '0);
   assign o_op.imm_bit  = imm_q[0];

endmodule

// File: verilog/rv_state.sv
`timescale 1ns/1ps

module rv_state import core_pkg::*; (
   input  logic i_clk,
   input  logic i_rst_n,
   input  logic i_ibus_ack,
   input  logic i_rf_ready,
   exec_if.seq  i_op,
   output logic o_rf_rreq,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_wen,
   output logic o_next
);

   localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(XLEN - 1);

   logic             rreq;
   logic             wait_ready;
   logic             cnt_en;
   logic [CNT_W-1:0] cnt;
   logic             last;

   assign last = cnt_en && (cnt == LAST_BIT);

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         rreq       <= 1'b0;
         wait_ready <= 1'b0;
         cnt_en     <= 1'b0;
         cnt        <= '0;
      end else begin
         rreq <= i_ibus_ack;
         // Operands are requested once, then we wait for the RF
         if (rreq) begin
            wait_ready <= 1'b1;
         end else if (i_rf_ready) begin
            wait_ready <= 1'b0;
         end
         if (wait_ready && i_rf_ready) begin
            cnt_en <= 1'b1;
         end else if (last) begin
            cnt_en <= 1'b0;
         end
         if (cnt_en) begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   assign o_rf_rreq = rreq;
   assign o_cnt_en  = cnt_en;
   assign o_cnt0    = cnt_en && (cnt == '0);
   assign o_wen     = cnt_en && i_op.rd_wen;
   assign o_next    = last;

endmodule

// File: verilog/rv_alu.sv
`timescale 1ns/1ps

module rv_alu import core_pkg::*; (
   input  logic i_clk,
   input  logic i_rst_n,
   input  logic i_cnt_en,
   input  logic i_cnt0,
   input  logic i_rs1,
   input  logic i_rs2,
   exec_if.alu  i_op,
   output logic o_rd
);

   logic sub;
   logic op_b;
   logic b_add;
   logic carry_in;
   logic carry_q;
   logic sum;
   logic carry_out;
   logic rd_bit;

   assign sub  = (i_op.alu_op == ALU_SUB);
   assign op_b = i_op.use_imm ? i_op.imm_bit : i_rs2;

   // Subtract as rs1 + ~rs2 + 1
   assign b_add     = op_b ^ sub;
   assign carry_in  = i_cnt0 ? sub : carry_q;
   assign sum       = i_rs1 ^ b_add ^ carry_in;
   assign carry_out = (i_rs1 & b_add) | ((i_rs1 ^ b_add) & carry_in);

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
      end else if (i_cnt_en) begin
         carry_q <= carry_out;
      end
   end

   always_comb begin
      case (i_op.alu_op)
         ALU_AND: rd_bit = i_rs1 & op_b;
         ALU_OR:  rd_bit = i_rs1 | op_b;
         ALU_XOR: rd_bit = i_rs1 ^ op_b;
         default: rd_bit = sum;
      endcase
   end

   assign o_rd = rd_bit;

endmodule

// File: verilog/serial_core_top.sv
`timescale 1ns/1ps

module serial_core_top import core_pkg::*; #(
   parameter logic [XLEN-1:0] RESET_PC = '0
) (
   input  logic            i_clk,
   input  logic            i_rst_n,
   input  logic [31:0]     i_ibus_rdt,
   input  logic            i_ibus_ack,
   input  logic            i_rf_ready,
   input  logic            i_rdata0,
   input  logic            i_rdata1,
   output logic            o_ibus_cyc,
   output logic [XLEN-1:0] o_ibus_adr,
   output logic            o_rf_rreq,
   output reg_addr_t       o_rreg0,
   output reg_addr_t       o_rreg1,
   output reg_addr_t       o_wreg,
   output logic            o_wen,
   output logic            o_wdata
);

   logic cnt_en;
   logic cnt0;
   logic next;

   exec_if op ();

   rv_fetch #(
      .RESET_PC (RESET_PC)
   ) fetch (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_next     (next),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ibus_adr (o_ibus_adr)
   );

   rv_decode decode (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_cnt_en   (cnt_en),
      .o_op       (op.decode)
   );

   rv_state state (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .i_op       (op.seq),
      .o_rf_rreq  (o_rf_rreq),
      .o_cnt_en   (cnt_en),
      .o_cnt0     (cnt0),
      .o_wen      (o_wen),
      .o_next     (next)
   );

   rv_alu alu (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_cnt_en (cnt_en),
      .i_cnt0   (cnt0),
      .i_rs1    (i_rdata0),
      .i_rs2    (i_rdata1),
      .i_op     (op.alu),
      .o_rd     (o_wdata)
   );

   // Register numbers
   assign o_rreg0 = op.rs1_addr;
   assign o_rreg1 = op.rs2_addr;
   assign o_wreg  = op.rd_addr;

endmodule

// File: bench/tb_serial_core.sv
`timescale 1ns/1ps

module tb_serial_core import core_pkg::*, isa_pkg::*; ();

   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;
   localparam int CLK_PERIOD = 40;
   localparam int RST_CYCLES = 16;
   localparam int N_INSTR    = 300;

   typedef enum logic [1:0] {RF_IDLE, RF_WAIT, RF_READY, RF_EXEC} rf_phase_e;

   logic            i_clk, i_rst_n, i_ibus_ack, i_rf_ready, i_rdata0, i_rdata1;
   logic [31:0]     i_ibus_rdt;
   logic            o_ibus_cyc, o_rf_rreq, o_wen, o_wdata;
   logic [XLEN-1:0] o_ibus_adr;
   reg_addr_t       o_rreg0, o_rreg1, o_wreg;

   // Inputs for the next cycle, decided on the falling edge
   logic            nx_ack, nx_ready, nx_rdata0, nx_rdata1;
   logic [31:0]     nx_rdt;

   logic [31:0]      rng;
   logic [XLEN-1:0]  rf_mem [32];
   logic [XLEN-1:0]  exp_pc, op_a, op_b, exp_val, wr_word;
   instr_u           cur;
   logic             exp_wen, ack_last, in_flight, expect_fetch, running;
   rf_phase_e        rf_phase;
   logic [CNT_W-1:0] bit_pos;
   int               ibus_wait, rf_delay, done_cnt, writes, mismatches, failures;

   serial_core_top #(
      .RESET_PC (RESET_PC)
   ) UUT (
      .i_clk (i_clk), .i_rst_n (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt), .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready), .i_rdata0 (i_rdata0), .i_rdata1 (i_rdata1),
      .o_ibus_cyc (o_ibus_cyc), .o_ibus_adr (o_ibus_adr), .o_rf_rreq (o_rf_rreq),
      .o_rreg0 (o_rreg0), .o_rreg1 (o_rreg1), .o_wreg (o_wreg),
      .o_wen (o_wen), .o_wdata (o_wdata)
   );

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   task automatic log_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
      $display("MISMATCH %s expected %08h actual %08h at %0t", name, exp, act, $time);
      mismatches++;
   endtask

   task automatic flag_problem(input string what);
      $display("At %0t: %s", $time, what);
      failures++;
   endtask

   task automatic print_counts();
      $display("Instructions %0d, writes %0d, mismatches %0d, other failures %0d",
               done_cnt, writes, mismatches, failures);
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // Mostly supported ops, some rd=0, some unknown opcode or funct3
   function automatic instr_u gen_instr();
      logic [31:0] r;
      logic [2:0]  f3;
      instr_u      w;
      r = next_rand();
      w = next_rand();
      f3 = (r[1:0] == 2'd0) ? F3_ADD : (r[1:0] == 2'd1) ? F3_XOR :
           (r[1:0] == 2'd2) ? F3_OR : F3_AND;
      if (r[5:2] < 4'd7) begin
         w.r.opcode = OPC_OP;
         w.r.funct3 = f3;
         w.r.funct7 = (f3 == F3_ADD && r[6]) ? 7'b0100000 : 7'b0000000;
      end else if (r[5:2] < 4'd13) begin
         w.i.opcode = OPC_OP_IMM;
         w.i.funct3 = f3;
      end else if (r[5:2] == 4'd13) begin
         w.r.opcode = r[7] ? OPC_OP : OPC_OP_IMM;
         w.r.funct3 = f3;
         w.r.funct7 = 7'b0000000;
         w.r.rd     = 5'd0;
      end else if (r[5:2] == 4'd14) begin
         // LUI, outside the decoded set
         w.r.opcode = 7'b0110111;
      end else begin
         w.r.opcode = r[7] ? OPC_OP : OPC_OP_IMM;
         w.r.funct3 = r[8] ? 3'b001 : 3'b010;
         w.r.funct7 = 7'b0000000;
      end
      return w;
   endfunction

   function automatic logic should_write(input instr_u ins);
      logic f3_ok;
      logic ok;
      f3_ok = ins.r.funct3 inside {F3_ADD, F3_XOR, F3_OR, F3_AND};
      ok = 1'b0;
      if (ins.r.opcode == OPC_OP) begin
         ok = (ins.r.funct7 == 7'b0000000 && f3_ok) ||
              (ins.r.funct7 == 7'b0100000 && ins.r.funct3 == F3_ADD);
      end else if (ins.i.opcode == OPC_OP_IMM) begin
         ok = f3_ok;
      end
      return ok && (ins.r.rd != 5'd0);
   endfunction

   function automatic logic [XLEN-1:0] compute_result(input instr_u ins,
                                                      input logic [XLEN-1:0] a,
                                                      input logic [XLEN-1:0] b);
      logic [XLEN-1:0] rhs;
      logic            is_sub;
      logic [XLEN-1:0] res;
      rhs    = (ins.i.opcode == OPC_OP_IMM) ? XLEN'($signed(ins.i.imm12)) : b;
      is_sub = (ins.r.opcode == OPC_OP) && ins.r.funct7[5];
      case (ins.r.funct3)
         F3_ADD:  res = is_sub ? a - rhs : a + rhs;
         F3_XOR:  res = a ^ rhs;
         F3_OR:   res = a | rhs;
         F3_AND:  res = a & rhs;
         default: res = '0;
      endcase
      return res;
   endfunction

   always @(posedge i_clk) begin
      i_ibus_ack <= nx_ack;
      i_ibus_rdt <= nx_rdt;
      i_rf_ready <= nx_ready;
      i_rdata0   <= nx_rdata0;
      i_rdata1   <= nx_rdata1;
   end

   // Bus models and checks, all on the falling edge
   always @(negedge i_clk) begin
      if (running) begin
         assert (o_rf_rreq == ack_last)
            else log_mismatch("o_rf_rreq", 32'(ack_last), 32'(o_rf_rreq));
         ack_last = i_ibus_ack;
         if (o_rf_rreq) begin
            assert (o_rreg0 == cur.r.rs1)
               else log_mismatch("o_rreg0", 32'(cur.r.rs1), 32'(o_rreg0));
            assert (o_rreg1 == cur.r.rs2)
               else log_mismatch("o_rreg1", 32'(cur.r.rs2), 32'(o_rreg1));
            assert (rf_phase == RF_IDLE) else flag_problem("read request during an open request");
         end
         if (expect_fetch) begin
            assert (o_ibus_cyc) else flag_problem("no fetch right after the last execute cycle");
            expect_fetch = 1'b0;
         end
         if (in_flight && !i_ibus_ack) begin
            assert (!o_ibus_cyc) else flag_problem("fetch started while an instruction executes");
         end
         if (rf_phase != RF_EXEC) begin
            assert (!o_wen) else flag_problem("o_wen high outside execute");
         end

         // Instruction memory with 0 to 3 wait cycles
         nx_ack = 1'b0;
         if (o_ibus_cyc && !i_ibus_ack && !in_flight) begin
            assert (o_ibus_adr == exp_pc) else log_mismatch("o_ibus_adr", exp_pc, o_ibus_adr);
            if (ibus_wait < 0) begin
               ibus_wait = int'(next_rand() % 32'd4);
            end
            if (ibus_wait == 0) begin
               cur       = gen_instr();
               nx_ack    = 1'b1;
               nx_rdt    = cur;
               exp_pc    = exp_pc + XLEN'(4);
               in_flight = 1'b1;
               ibus_wait = -1;
            end else begin
               ibus_wait--;
            end
         end

         // Register file, operands lsb first
         case (rf_phase)
            RF_IDLE: begin
               if (o_rf_rreq) begin
                  rf_delay = int'(next_rand() % 32'd4);
                  rf_phase = RF_WAIT;
               end
            end
            RF_WAIT: begin
               if (rf_delay == 0) begin
                  nx_ready = 1'b1;
                  rf_phase = RF_READY;
               end else begin
                  rf_delay--;
               end
            end
            RF_READY: begin
               nx_ready  = 1'b0;
               op_a      = rf_mem[cur.r.rs1];
               op_b      = rf_mem[cur.r.rs2];
               exp_wen   = should_write(cur);
               exp_val   = compute_result(cur, op_a, op_b);
               bit_pos   = '0;
               wr_word   = '0;
               nx_rdata0 = op_a[0];
               nx_rdata1 = op_b[0];
               rf_phase  = RF_EXEC;
            end
            RF_EXEC: begin
               assert (o_wen == exp_wen) else log_mismatch("o_wen", 32'(exp_wen), 32'(o_wen));
               if (o_wen) begin
                  assert (o_wreg == cur.r.rd)
                     else log_mismatch("o_wreg", 32'(cur.r.rd), 32'(o_wreg));
               end
               wr_word[bit_pos] = o_wdata;
               if (bit_pos == CNT_W'(XLEN - 1)) begin
                  nx_rdata0 = 1'b0;
                  nx_rdata1 = 1'b0;
                  if (exp_wen) begin
                     assert (wr_word == exp_val) else log_mismatch("o_wdata", exp_val, wr_word);
                     rf_mem[cur.r.rd] = exp_val;
                     writes++;
                  end
                  in_flight    = 1'b0;
                  expect_fetch = 1'b1;
                  done_cnt++;
                  rf_phase = RF_IDLE;
               end else begin
                  bit_pos   = bit_pos + CNT_W'(1);
                  nx_rdata0 = op_a[bit_pos];
                  nx_rdata1 = op_b[bit_pos];
               end
            end
            default: rf_phase = RF_IDLE;
         endcase
      end
   end

   initial begin
      i_clk = 1'b0;
      i_rst_n = 1'b0;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_rf_ready = 1'b0;
      i_rdata0 = 1'b0;
      i_rdata1 = 1'b0;
      {nx_ack, nx_ready, nx_rdata0, nx_rdata1} = '0;
      nx_rdt = '0;
      rng = 32'h5a59_14ce;
      rf_mem[0] = '0;
      for (int r = 1; r < 32; r++) begin
         rf_mem[5'(r)] = next_rand();
      end
      exp_pc = RESET_PC;
      cur = '0;
      {op_a, op_b, exp_val, wr_word} = '0;
      {exp_wen, ack_last, in_flight, expect_fetch, running} = '0;
      rf_phase = RF_IDLE;
      bit_pos = '0;
      ibus_wait = -1;
      {rf_delay, done_cnt, writes, mismatches, failures} = '0;

      repeat (RST_CYCLES) @(posedge i_clk);
      i_rst_n <= 1'b1;
      running <= 1'b1;
      @(negedge i_clk);
      assert (o_ibus_cyc) else flag_problem("o_ibus_cyc low after reset");
      assert (o_ibus_adr == RESET_PC) else log_mismatch("o_ibus_adr", RESET_PC, o_ibus_adr);
      assert (!o_rf_rreq) else flag_problem("o_rf_rreq high after reset");
      assert (!o_wen) else flag_problem("o_wen high after reset");

      wait (done_cnt >= N_INSTR);
      repeat (2) @(negedge i_clk);
      print_counts();
      if (mismatches + failures == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Watchdog, 50 cycles per instruction
   initial begin
      #(N_INSTR * 50 * CLK_PERIOD);
      $display("Timeout after %0d of %0d instructions", done_cnt, N_INSTR);
      print_counts();
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: sim.f
verilog/core_pkg.sv
verilog/isa_pkg.sv
verilog/exec_if.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_state.sv
verilog/rv_alu.sv
verilog/serial_core_top.sv
bench/tb_serial_core.sv

// File: Makefile
# Verilator build and run for the serial core testbench

VERILATOR ?= verilator
TOP       ?= tb_serial_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert -j 0
SIM_BIN    = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
